/* design/bit_reverse_reorder.sv */
`timescale 1ns/10ps

module bit_reverse_reorder import rbo_sample_pkg::*, rbo_frame_pkg::*; (
        input  logic   clock,
        input  logic   reset,
        input  logic   in_valid,
        input  data_t  in_re,
        input  data_t  in_im,
        output logic   out_valid,
        output data_t  out_re,
        output data_t  out_im,
        output index_t out_index
);

        logic    write_enable;
        bank_t   write_bank;
        index_t  write_index;
        bank_t   read_bank;
        index_t  read_index;
        index_t  read_count;
        logic    read_valid;
        sample_t write_sample;
        logic    bank0_strobe;
        logic    bank1_strobe;
        sample_t bank0_sample;
        sample_t bank1_sample;

        assign write_sample.re = in_re;
        assign write_sample.im = in_im;

        // Only the bank owned by the writer takes the sample
        assign bank0_strobe = write_enable && (write_bank == 1'b0);
        assign bank1_strobe = write_enable && (write_bank == 1'b1);

        reorder_ctrl ctrl_i (
                .clock        (clock),
                .reset        (reset),
                .in_valid     (in_valid),
                .write_enable (write_enable),
                .write_bank   (write_bank),
                .write_index  (write_index),
                .read_bank    (read_bank),
                .read_index   (read_index),
                .read_count   (read_count),
                .read_valid   (read_valid)
        );

        sample_bank bank0_i (
                .clock        (clock),
                .write_strobe (bank0_strobe),
                .write_index  (write_index),
                .write_sample (write_sample),
                .read_index   (read_index),
                .read_sample  (bank0_sample)
        );

        sample_bank bank1_i (
                .clock        (clock),
                .write_strobe (bank1_strobe),
                .write_index  (write_index),
                .write_sample (write_sample),
                .read_index   (read_index),
                .read_sample  (bank1_sample)
        );

        reorder_output output_i (
                .clock        (clock),
                .reset        (reset),
                .read_valid   (read_valid),
                .read_bank    (read_bank),
                .read_count   (read_count),
                .bank0_sample (bank0_sample),
                .bank1_sample (bank1_sample),
                .out_valid    (out_valid),
                .out_re       (out_re),
                .out_im       (out_im),
                .out_index    (out_index)
        );

endmodule

/* design/rbo_frame_pkg.sv */
`include "rbo_macros.svh"

package rbo_frame_pkg;

        typedef logic [`RBO_FRAME_LOG2-1:0] index_t;    // Position within a frame
        typedef logic bank_t;                           // Ping-pong bank number

        // Mirror the index so bit 0 becomes the MSB
        function automatic index_t bit_reverse(input index_t idx);
                index_t rev;
                rev = '0;
                for (int i = 0; i < `RBO_FRAME_LOG2; i++) begin
                        rev[`RBO_FRAME_LOG2-1-i] = idx[i];
                end
                return rev;
        endfunction

endpackage

/* design/rbo_sample_pkg.sv */
`include "rbo_macros.svh"

package rbo_sample_pkg;

        // One signed real or imaginary part
        typedef logic signed [`RBO_DATA_WIDTH-1:0] data_t;

        // Complex sample as stored in the banks
        typedef struct packed {
                data_t re;      // Upper half
                data_t im;      // Lower half
        } sample_t;

endpackage

/* design/reorder_ctrl.sv */
`timescale 1ns/10ps

`include "rbo_macros.svh"

module reorder_ctrl import rbo_frame_pkg::*; (
        input  logic   clock,
        input  logic   reset,
        input  logic   in_valid,
        output logic   write_enable,
        output bank_t  write_bank,
        output index_t write_index,
        output bank_t  read_bank,
        output index_t read_index,
        output index_t read_count,
        output logic   read_valid
);

        localparam index_t LAST_INDEX = index_t'(`RBO_FRAME_LEN - 1);

        logic   frame_done;     // Sample 127 accepted this cycle
        logic   last_beat;      // Final read beat of the current pass
        logic   start_read;
        logic   pending;        // Completed frame waiting for the reader
        index_t next_count;

        assign write_enable = in_valid;
        assign frame_done   = in_valid && (write_index == LAST_INDEX);
        assign last_beat    = read_valid && (read_count == LAST_INDEX);
        assign start_read   = (frame_done || pending) && (!read_valid || last_beat);
        assign next_count   = read_count + 1'b1;

        // Write side counts accepted samples and flips banks per frame
        always_ff @(posedge clock) begin
                if (reset) begin
                        write_index <= '0;
                        write_bank  <= '0;
                end else if (in_valid) begin
                        if (frame_done) begin
                                write_index <= '0;
                                write_bank  <= ~write_bank;     // Filled bank goes to reader
                        end else begin
                                write_index <= write_index + 1'b1;
                        end
                end
        end

        // Read side walks the natural count and issues reversed addresses
        always_ff @(posedge clock) begin
                if (reset) begin
                        read_valid <= 1'b0;
                        read_count <= '0;
                        read_index <= '0;
                        read_bank  <= '0;
                        pending    <= 1'b0;
                end else if (start_read) begin
                        read_valid <= 1'b1;
                        read_count <= '0;
                        read_index <= bit_reverse('0);
                        // A waiting frame sits in the bank opposite the writer
                        read_bank  <= pending ? ~write_bank : write_bank;
                        pending    <= pending && frame_done;
                end else begin
                        if (frame_done) begin
                                pending <= 1'b1;        // Reader still busy
                        end
                        if (read_valid) begin
                                read_count <= next_count;
                                read_index <= bit_reverse(next_count);
                                if (last_beat) begin
                                        read_valid <= 1'b0;
                                end
                        end
                end
        end

endmodule

/* design/reorder_output.sv */
`timescale 1ns/10ps

module reorder_output import rbo_sample_pkg::*, rbo_frame_pkg::*; (
        input  logic    clock,
        input  logic    reset,
        input  logic    read_valid,
        input  bank_t   read_bank,
        input  index_t  read_count,
        input  sample_t bank0_sample,
        input  sample_t bank1_sample,
        output logic    out_valid,
        output data_t   out_re,
        output data_t   out_im,
        output index_t  out_index
);

        logic    valid_d;
        bank_t   bank_d;
        index_t  count_d;
        sample_t selected;

        // Align control with the bank read latency
        always_ff @(posedge clock) begin
                if (reset) begin
                        valid_d <= 1'b0;
                end else begin
                        valid_d <= read_valid;
                end
        end

        always_ff @(posedge clock) begin
                bank_d  <= read_bank;
                count_d <= read_count;
        end

        assign selected = bank_d ? bank1_sample : bank0_sample;

        always_ff @(posedge clock) begin
                if (reset) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= valid_d;
                end
        end

        // Data and natural index follow the valid flag
        always_ff @(posedge clock) begin
                out_re    <= selected.re;
                out_im    <= selected.im;
                out_index <= count_d;
        end

endmodule

/* design/sample_bank.sv */
`timescale 1ns/10ps

`include "rbo_macros.svh"

module sample_bank import rbo_sample_pkg::*, rbo_frame_pkg::*; (
        input  logic    clock,
        input  logic    write_strobe,
        input  index_t  write_index,
        input  sample_t write_sample,
        input  index_t  read_index,
        output sample_t read_sample
);

        sample_t mem [0:`RBO_FRAME_LEN-1];      // One frame in natural order

        always_ff @(posedge clock) begin
                if (write_strobe) begin
                        mem[write_index] <= write_sample;
                end
        end

        // Registered read with data one cycle after the address
        always_ff @(posedge clock) begin
                read_sample <= mem[read_index];
        end

endmodule

/* dv/reorder_properties.sv */
`timescale 1ns/10ps

`include "rbo_macros.svh"

module reorder_properties import rbo_sample_pkg::*, rbo_frame_pkg::*; (
        input logic   clock,
        input logic   reset,
        input logic   in_valid,
        input logic   out_valid,
        input data_t  out_re,
        input data_t  out_im,
        input index_t out_index
);

        localparam index_t LAST_INDEX = index_t'(`RBO_FRAME_LEN - 1);
        localparam int FRAME_BITS = `RBO_DATA_WIDTH - `RBO_FRAME_LOG2;

        index_t                in_count;        // Accepted samples in the current input frame
        logic                  accept_last;
        logic                  frame_seen;      // At least one frame fully accepted
        logic                  prev_valid;
        index_t                prev_index;
        logic [FRAME_BITS-1:0] expected_frame;
        int                    frames_out;
        int                    error_count = 0;

        // Natural index expected on an output beat, LSB shifted out first
        function automatic index_t mirror_index(input index_t idx);
                index_t rest;
                index_t rev;
                rest = idx;
                rev  = '0;
                repeat (`RBO_FRAME_LOG2) begin
                        rev  = (rev << 1) | (rest & 1'b1);
                        rest = rest >> 1;
                end
                return rev;
        endfunction

        assign accept_last = in_valid && (in_count == LAST_INDEX);

        always_ff @(posedge clock) begin
                if (reset) begin
                        in_count       <= '0;
                        frame_seen     <= 1'b0;
                        prev_valid     <= 1'b0;
                        prev_index     <= '0;
                        expected_frame <= '0;
                        frames_out     <= 0;
                end else begin
                        if (in_valid) begin
                                in_count <= in_count + 1'b1;    // Wraps at the frame length
                        end
                        if (accept_last) begin
                                frame_seen <= 1'b1;
                        end
                        prev_valid <= out_valid;
                        prev_index <= out_index;
                        if (out_valid && (out_index == LAST_INDEX)) begin
                                expected_frame <= expected_frame + 1'b1;
                                frames_out     <= frames_out + 1;
                        end
                end
        end

        quiet_a: assert property (@(posedge clock) disable iff (reset)
                        !frame_seen |-> !out_valid)
        else begin
                error_count++;
                $error("Fail out_valid 0x%h before any full frame, expected 0x0",
                       $sampled(out_valid));
        end

        // Each beat carries the sample whose natural index is the mirrored output index
        reverse_a: assert property (@(posedge clock) disable iff (reset)
                        out_valid |-> out_re[`RBO_FRAME_LOG2-1:0] == mirror_index(out_index))
        else begin
                error_count++;
                $error("Fail out_re 0x%h at out_index 0x%h, expected low bits 0x%h",
                       $sampled(out_re), $sampled(out_index),
                       mirror_index($sampled(out_index)));
        end

        inverse_a: assert property (@(posedge clock) disable iff (reset)
                        out_valid |-> out_im == ~out_re)
        else begin
                error_count++;
                $error("Fail out_im 0x%h, expected 0x%h", $sampled(out_im), ~$sampled(out_re));
        end

        early_a: assert property (@(posedge clock) disable iff (reset)
                        accept_last |-> ##2 (!out_valid || out_index == LAST_INDEX))
        else begin
                error_count++;
                $error("Fail out_index 0x%h before a new frame, expected 0x%h or idle",
                       $sampled(out_index), LAST_INDEX);
        end

        start_a: assert property (@(posedge clock) disable iff (reset)
                        accept_last |-> ##3 (out_valid && out_index == '0))
        else begin
                error_count++;
                $error("Fail out_valid 0x%h out_index 0x%h at start, expected 0x1 and 0x00",
                       $sampled(out_valid), $sampled(out_index));
        end

        first_beat_a: assert property (@(posedge clock) disable iff (reset)
                        out_valid && !prev_valid |-> out_index == '0)
        else begin
                error_count++;
                $error("Fail out_index 0x%h on the first beat, expected 0x00",
                       $sampled(out_index));
        end

        // No hole and no skipped index inside a frame
        step_a: assert property (@(posedge clock) disable iff (reset)
                        prev_valid && prev_index != LAST_INDEX
                        |-> out_valid && out_index == prev_index + 1'b1)
        else begin
                error_count++;
                $error("Fail out_valid 0x%h out_index 0x%h, expected 0x1 and 0x%h",
                       $sampled(out_valid), $sampled(out_index),
                       index_t'($sampled(prev_index) + 1'b1));
        end

        frame_a: assert property (@(posedge clock) disable iff (reset)
                        out_valid |-> out_re[`RBO_DATA_WIDTH-1:`RBO_FRAME_LOG2] == expected_frame)
        else begin
                error_count++;
                $error("Fail out_re frame number 0x%h, expected 0x%h",
                       $sampled(out_re[`RBO_DATA_WIDTH-1:`RBO_FRAME_LOG2]),
                       $sampled(expected_frame));
        end

endmodule

bind bit_reverse_reorder reorder_properties props_i (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_index (out_index)
);

/* dv/tb_bit_reverse_reorder.sv */
`timescale 1ns/10ps

`include "rbo_macros.svh"

module tb_bit_reverse_reorder import rbo_sample_pkg::*; ();

        localparam int NUM_FRAMES = 6;
        localparam int FIRST_GAP_FRAME = 3;     // Later frames see random input gaps
        localparam int CYCLE_LIMIT = NUM_FRAMES * 256 + 200;

        logic                       clock;
        logic                       reset;
        logic                       in_valid;
        data_t                      in_re;
        data_t                      in_im;
        logic                       out_valid;
        data_t                      out_re;
        data_t                      out_im;
        logic [`RBO_FRAME_LOG2-1:0] out_index;
        integer                     seed;
        int                         cycle_count = 0;

        tb_clock_gen clock_gen_i (
                .clock (clock),
                .reset (reset)
        );

        bit_reverse_reorder dut_i (
                .clock     (clock),
                .reset     (reset),
                .in_valid  (in_valid),
                .in_re     (in_re),
                .in_im     (in_im),
                .out_valid (out_valid),
                .out_re    (out_re),
                .out_im    (out_im),
                .out_index (out_index)
        );

        // Frame number above the natural index
        function automatic data_t make_sample_re(input int frame, input int index);
                return data_t'((frame << `RBO_FRAME_LOG2) | index);
        endfunction

        task automatic send_frame(input int frame, input bit with_gaps);
                int index;
                index = 0;
                while (index < `RBO_FRAME_LEN) begin
                        @(posedge clock);
                        if (with_gaps && (($random(seed) & 3) == 0)) begin
                                in_valid <= 1'b0;
                        end else begin
                                in_valid <= 1'b1;
                                in_re    <= make_sample_re(frame, index);
                                in_im    <= ~make_sample_re(frame, index);
                                index++;
                        end
                end
        endtask

        task automatic report_counts(input int timeouts);
                $display("Error counts: assertion failures %0d, timeouts %0d",
                         dut_i.props_i.error_count, timeouts);
        endtask

        // Watchdog
        always @(posedge clock) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count == CYCLE_LIMIT) begin
                        $display("Timeout after %0d cycles with %0d of %0d frames sent out",
                                 CYCLE_LIMIT, dut_i.props_i.frames_out, NUM_FRAMES);
                        report_counts(1);
                        $display("Simulation finished: FAIL");
                        $finish;
                end
        end

        initial begin
                in_valid = 1'b0;
                in_re    = '0;
                in_im    = '0;
                seed     = 32'h2132;

                @(posedge clock);
                while (reset) begin
                        @(posedge clock);
                end

                for (int frame = 0; frame < NUM_FRAMES; frame++) begin
                        send_frame(frame, frame >= FIRST_GAP_FRAME);
                end
                @(posedge clock);
                in_valid <= 1'b0;

                // Let the last frame drain out of both banks
                while (dut_i.props_i.frames_out < NUM_FRAMES) begin
                        @(posedge clock);
                end
                repeat (4) @(posedge clock);

                report_counts(0);
                if (dut_i.props_i.error_count == 0) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
        output logic clock,
        output logic reset
);

        localparam int HALF_PERIOD = 5;         // 10 ns clock
        localparam int RESET_CYCLES = 3;

        initial begin
                clock = 1'b0;
                forever #HALF_PERIOD clock = ~clock;
        end

        initial begin
                reset = 1'b1;
                repeat (RESET_CYCLES) @(posedge clock);
                reset <= 1'b0;
        end

endmodule

/* include/rbo_macros.svh */
`ifndef RBO_MACROS_SVH
`define RBO_MACROS_SVH

// Width of one real or imaginary component
`define RBO_DATA_WIDTH 16

// Frame geometry of the 128-point FFT output
`define RBO_FRAME_LOG2 7
`define RBO_FRAME_LEN  (1 << `RBO_FRAME_LOG2)

`endif

/* tb.f */
+incdir+include
design/rbo_sample_pkg.sv
design/rbo_frame_pkg.sv
design/reorder_ctrl.sv
design/sample_bank.sv
design/reorder_output.sv
design/bit_reverse_reorder.sv
dv/tb_clock_gen.sv
dv/reorder_properties.sv
dv/tb_bit_reverse_reorder.sv
